//--- logic/sram_tc_pkg.sv
package sram_tc_pkg;

   // populated banks on the chip
   localparam int NUM_BANKS = 3;

   // per-bank geometry, index matches the bank number in the address
   // bank 0 is the 8 bit by 1024 word macro
   // banks 1 and 2 are 32 bits wide, 256 and 512 words deep
   localparam int BANK_DATA_W [NUM_BANKS] = '{8, 32, 32};
   localparam int BANK_ADDR_W [NUM_BANKS] = '{10, 8, 9};

   // bus side data width and the widest word address of any bank
   localparam int DATA_W     = 32;
   localparam int MAX_ADDR_W = 10;

   typedef logic [DATA_W-1:0]     word_t;
   typedef logic [MAX_ADDR_W-1:0] waddr_t;
   typedef logic [DATA_W/8-1:0]   wmask_t;
   typedef logic [NUM_BANKS-1:0]  bank_vec_t;

   // bank field of the bus address, wide enough for unmapped indices
   typedef logic [2:0] bank_idx_t;

   // level-decoded test mode, only MODE_WB reaches the banks
   typedef enum logic [1:0] {
      MODE_LA   = 2'd0,
      MODE_GPIO = 2'd1,
      MODE_WB   = 2'd2,
      MODE_RRAM = 2'd3
   } mode_t;

   // shared request to all banks, each bank picks its own csb bits
   // csb bits are active low
   typedef struct packed {
      waddr_t    addr0;
      word_t     din0;
      logic      we0;
      wmask_t    wmask0;
      bank_vec_t csb0;
      waddr_t    addr1;
      bank_vec_t csb1;
   } mem_req_t;

   // which captured port output goes back on the bus
   typedef struct packed {
      bank_idx_t bank;
      logic      port;
   } rd_sel_t;

endpackage

//--- logic/wb_pkg.sv
package wb_pkg;

   // classic wishbone slave widths
   localparam int ADR_W = 32;
   localparam int DAT_W = 32;
   localparam int SEL_W = DAT_W / 8;

   // address map
   // bits 15:13 pick the bank
   localparam int ADR_BANK_LSB = 13;
   // bit 12 set means the read-only port
   localparam int ADR_PORT_BIT = 12;
   // bits 11:2 are the word index
   localparam int ADR_WORD_LSB = 2;
   localparam int ADR_WORD_W   = 10;

   // master to slave
   typedef struct packed {
      logic             cyc;
      logic             stb;
      logic             we;
      logic [SEL_W-1:0] sel;
      logic [ADR_W-1:0] adr;
      logic [DAT_W-1:0] dat;
   } wb_req_t;

   // slave to master
   typedef struct packed {
      logic             ack;
      logic [DAT_W-1:0] dat;
   } wb_rsp_t;

endpackage

//--- logic/sram_1rw1r.sv
module sram_1rw1r #(
   parameter int DATA_W = 32,
   parameter int ADDR_W = 8
) (
   input  logic                clk,
   // port 0, read-write
   input  logic                csb0_i,
   input  logic                web0_i,
   input  logic [DATA_W/8-1:0] wmask0_i,
   input  logic [ADDR_W-1:0]   addr0_i,
   input  logic [DATA_W-1:0]   din0_i,
   output logic [DATA_W-1:0]   dout0_o,
   // port 1, read only
   input  logic                csb1_i,
   input  logic [ADDR_W-1:0]   addr1_i,
   output logic [DATA_W-1:0]   dout1_o
);

   localparam int NUM_BYTES = DATA_W / 8;
   localparam int DEPTH     = 1 << ADDR_W;

   // storage array
   logic [DATA_W-1:0] mem [DEPTH];

   // port 0
   // write enabled bytes, or read into the output register
   // output holds on a write and while deselected
   always_ff @(posedge clk) begin
      if (!csb0_i) begin
         if (!web0_i) begin
            for (int i = 0; i < NUM_BYTES; i++) begin
               if (wmask0_i[i]) begin
                  mem[addr0_i][i*8 +: 8] <= din0_i[i*8 +: 8];
               end
            end
         end else begin
            dout0_o <= mem[addr0_i];
         end
      end
   end

   // port 1
   // registered read, holds while deselected
   always_ff @(posedge clk) begin
      if (!csb1_i) begin
         dout1_o <= mem[addr1_i];
      end
   end

   // byte mask must be driven on every enabled write
   wmask_known_a: assert property (@(posedge clk)
      (!csb0_i && !web0_i) |-> !$isunknown(wmask0_i));

endmodule

//--- logic/dout_capture.sv
module dout_capture (
   input  logic                 clk,
   input  logic                 rstn,
   // zero-extended bank outputs
   input  sram_tc_pkg::word_t   dout0_i [sram_tc_pkg::NUM_BANKS],
   input  sram_tc_pkg::word_t   dout1_i [sram_tc_pkg::NUM_BANKS],
   // bank and port held by the controller
   input  sram_tc_pkg::rd_sel_t rd_sel_i,
   output sram_tc_pkg::word_t   rd_data_o
);
   import sram_tc_pkg::*;

   // captured port 0 outputs
   word_t data0_q [NUM_BANKS];
   // captured port 1 outputs
   word_t data1_q [NUM_BANKS];

   // every port is sampled on every clock
   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int b = 0; b < NUM_BANKS; b++) begin
            data0_q[b] <= '0;
            data1_q[b] <= '0;
         end
      end else begin
         for (int b = 0; b < NUM_BANKS; b++) begin
            data0_q[b] <= dout0_i[b];
            data1_q[b] <= dout1_i[b];
         end
      end
   end

   // read-back mux
   // unmapped bank index matches nothing and returns zero
   always_comb begin
      rd_data_o = '0;
      for (int b = 0; b < NUM_BANKS; b++) begin
         if (rd_sel_i.bank == bank_idx_t'(b)) begin
            // port bit picks the read-only port
            if (rd_sel_i.port) begin
               rd_data_o = data1_q[b];
            end else begin
               rd_data_o = data0_q[b];
            end
         end
      end
   end

endmodule

//--- logic/wb_sram_ctrl.sv
module wb_sram_ctrl (
   input  logic                  clk,
   input  logic                  rstn,
   input  sram_tc_pkg::mode_t    mode_i,
   input  wb_pkg::wb_req_t       wb_i,
   output wb_pkg::wb_rsp_t       wb_o,
   output sram_tc_pkg::mem_req_t mem_o,
   output sram_tc_pkg::rd_sel_t  rd_sel_o,
   input  sram_tc_pkg::word_t    rd_data_i
);
   import sram_tc_pkg::*;
   import wb_pkg::*;

   // one access walks every state, so latency is fixed
   typedef enum logic [2:0] {
      ST_IDLE,
      ST_ISSUE,
      ST_WAIT,
      ST_CAPTURE,
      ST_ACK
   } state_t;

   state_t state_q;
   state_t state_d;

   // request fields held for the whole access
   waddr_t    addr_q;
   word_t     din_q;
   wmask_t    sel_q;
   logic      we_q;
   bank_idx_t bank_q;
   logic      port_q;
   logic      wb_mode_q;

   // read data returned with ack
   word_t     dat_q;

   logic      start;
   logic      issue;
   logic      port0_en;
   logic      port1_en;
   bank_vec_t bank_oh;

   // new access only from idle, stb is ignored while busy
   assign start = (state_q == ST_IDLE) && wb_i.cyc && wb_i.stb;
   assign issue = (state_q == ST_ISSUE);

   always_comb begin
      state_d = state_q;
      unique case (state_q)
         ST_IDLE: begin
            if (start) begin
               state_d = ST_ISSUE;
            end
         end
         // csb low for this one cycle
         ST_ISSUE:   state_d = ST_WAIT;
         // bank output settles, capture samples it
         ST_WAIT:    state_d = ST_CAPTURE;
         ST_CAPTURE: state_d = ST_ACK;
         ST_ACK:     state_d = ST_IDLE;
         default:    state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state_q <= ST_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // latch and split the address at the accepting edge
   always_ff @(posedge clk) begin
      if (start) begin
         addr_q    <= wb_i.adr[ADR_WORD_LSB +: ADR_WORD_W];
         din_q     <= wb_i.dat;
         sel_q     <= wb_i.sel;
         we_q      <= wb_i.we;
         bank_q    <= wb_i.adr[ADR_BANK_LSB +: $bits(bank_idx_t)];
         port_q    <= wb_i.adr[ADR_PORT_BIT];
         wb_mode_q <= (mode_i == MODE_WB);
      end
   end

   // one-hot bank select
   // no bit for unmapped banks or outside wishbone mode
   always_comb begin
      for (int b = 0; b < NUM_BANKS; b++) begin
         bank_oh[b] = wb_mode_q && (bank_q == bank_idx_t'(b));
      end
   end

   // port 0 takes reads and writes
   assign port0_en = issue && !port_q;
   // port 1 is read only, writes to it are dropped
   assign port1_en = issue && port_q && !we_q;

   always_comb begin
      mem_o.addr0  = addr_q;
      mem_o.din0   = din_q;
      mem_o.we0    = we_q;
      mem_o.wmask0 = sel_q;
      mem_o.csb0   = ~(bank_oh & {NUM_BANKS{port0_en}});
      mem_o.addr1  = addr_q;
      mem_o.csb1   = ~(bank_oh & {NUM_BANKS{port1_en}});
   end

   // capture block picks the word, unmapped banks give zero there
   assign rd_sel_o = '{bank: bank_q, port: port_q};

   // writes and non-wishbone modes read back zero
   always_ff @(posedge clk) begin
      if (state_q == ST_CAPTURE) begin
         dat_q <= (wb_mode_q && !we_q) ? rd_data_i : '0;
      end
   end

   always_comb begin
      wb_o.ack = (state_q == ST_ACK);
      wb_o.dat = dat_q;
   end

   // ack is a single-cycle pulse
   ack_pulse_a: assert property (@(posedge clk) disable iff (!rstn)
      wb_o.ack |=> !wb_o.ack);

   // never more than one bank enabled per port
   csb_onehot_a: assert property (@(posedge clk) disable iff (!rstn)
      $onehot0(~mem_o.csb0) && $onehot0(~mem_o.csb1));

   // banks only see a chip select right after an accepted request
   csb_issue_only_a: assert property (@(posedge clk) disable iff (!rstn)
      !(&mem_o.csb0 && &mem_o.csb1) |-> $past(start));

endmodule

//--- logic/sram_testchip_top.sv
module sram_testchip_top (
   input  logic               clk,
   input  logic               rstn,
   input  sram_tc_pkg::mode_t mode_i,
   input  wb_pkg::wb_req_t    wb_i,
   output wb_pkg::wb_rsp_t    wb_o
);
   import sram_tc_pkg::*;

   // shared request to every bank
   mem_req_t mem;
   // read-back path
   rd_sel_t  rd_sel;
   word_t    rd_data;
   // bank outputs, zero-extended to the bus width
   word_t    dout0 [NUM_BANKS];
   word_t    dout1 [NUM_BANKS];

   wb_sram_ctrl u_ctrl (
      .clk       (clk),
      .rstn      (rstn),
      .mode_i    (mode_i),
      .wb_i      (wb_i),
      .wb_o      (wb_o),
      .mem_o     (mem),
      .rd_sel_o  (rd_sel),
      .rd_data_i (rd_data)
   );

   // one bank per geometry entry
   // narrow banks take the low slices, which also wraps the word index
   for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
      localparam int DW = BANK_DATA_W[g];
      localparam int AW = BANK_ADDR_W[g];

      logic [DW-1:0] bank_dout0;
      logic [DW-1:0] bank_dout1;

      sram_1rw1r #(
         .DATA_W (DW),
         .ADDR_W (AW)
      ) u_sram (
         .clk      (clk),
         .csb0_i   (mem.csb0[g]),
         .web0_i   (~mem.we0),
         .wmask0_i (mem.wmask0[DW/8-1:0]),
         .addr0_i  (mem.addr0[AW-1:0]),
         .din0_i   (mem.din0[DW-1:0]),
         .dout0_o  (bank_dout0),
         .csb1_i   (mem.csb1[g]),
         .addr1_i  (mem.addr1[AW-1:0]),
         .dout1_o  (bank_dout1)
      );

      assign dout0[g] = word_t'(bank_dout0);
      assign dout1[g] = word_t'(bank_dout1);
   end

   dout_capture u_capture (
      .clk       (clk),
      .rstn      (rstn),
      .dout0_i   (dout0),
      .dout1_i   (dout1),
      .rd_sel_i  (rd_sel),
      .rd_data_o (rd_data)
   );

endmodule

//--- dv/tb_sram_testchip.sv
module tb_sram_testchip;
   import sram_tc_pkg::*;
   import wb_pkg::*;

   localparam int CLK_PERIOD   = 10;
   localparam int RESET_CYCLES = 8;
   // rising edges from the request being sampled to ack being visible
   localparam int ACK_LATENCY  = 4;
   localparam int ACK_TIMEOUT  = 20;
   // watchdog sizing, the bank fill is the longest test
   localparam int NUM_TESTS    = 7;
   localparam int MAX_ACCESSES = 2000;
   localparam int WATCHDOG_T   = (NUM_TESTS * MAX_ACCESSES * 10 + RESET_CYCLES) * CLK_PERIOD;

   logic    clk;
   logic    rstn;
   mode_t   mode;
   wb_req_t wb_req;
   wb_rsp_t wb_rsp;

   // reference contents per bank, narrow banks keep their upper bytes at zero
   word_t ref_mem [NUM_BANKS][1 << MAX_ADDR_W];

   sram_testchip_top dut (
      .clk    (clk),
      .rstn   (rstn),
      .mode_i (mode),
      .wb_i   (wb_req),
      .wb_o   (wb_rsp)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic check_word(input string name, input word_t got, input word_t exp);
      assert (got === exp) else begin
         $display("CHECK FAILED time %0t %s expected %h got %h", $time, name, exp, got);
         $display("TEST FAILED");
         $fatal(1, "data mismatch");
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      assert (got == exp) else begin
         $display("CHECK FAILED time %0t %s expected %0d got %0d", $time, name, exp, got);
         $display("TEST FAILED");
         $fatal(1, "count mismatch");
      end
   endtask

   // bus address: bank in 15:13, port in 12, word index in 11:2
   function automatic logic [31:0] make_adr(logic [2:0] bank, logic port, logic [9:0] idx);
      return {16'h0, bank, port, idx, 2'b00};
   endfunction

   // expected read data from the decode rules
   function automatic word_t expect_read(mode_t m, logic [31:0] adr);
      int b;
      int idx;
      b = int'(adr[15:13]);
      if (m != MODE_WB || b >= NUM_BANKS) begin
         return '0;
      end
      // word index wraps at the bank depth
      idx = int'(adr[11:2]) % (1 << BANK_ADDR_W[b]);
      return ref_mem[b][idx];
   endfunction

   function automatic void ref_write(mode_t m, logic [31:0] adr, wmask_t sel, word_t dat);
      int b;
      int idx;
      int nbytes;
      b = int'(adr[15:13]);
      // other modes, unmapped banks and the read-only port drop writes
      if (m != MODE_WB || b >= NUM_BANKS || adr[12]) begin
         return;
      end
      nbytes = BANK_DATA_W[b] / 8;
      idx = int'(adr[11:2]) % (1 << BANK_ADDR_W[b]);
      for (int i = 0; i < nbytes; i++) begin
         if (sel[i]) begin
            ref_mem[b][idx][i*8 +: 8] = dat[i*8 +: 8];
         end
      end
   endfunction

   // one classic cycle, fields held until ack, stb dropped the cycle after
   task automatic wb_access(input logic we, input logic [31:0] adr, input wmask_t sel,
                            input word_t dat, output word_t rdata);
      int edges;
      @(negedge clk);
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      wb_req.we  = we;
      wb_req.sel = sel;
      wb_req.adr = adr;
      wb_req.dat = dat;
      edges = 0;
      do begin
         @(posedge clk);
         edges++;
         @(negedge clk);
      end while (!wb_rsp.ack && edges < ACK_TIMEOUT);
      if (!wb_rsp.ack) begin
         $display("no ack within %0d clock edges, adr %h at time %0t", ACK_TIMEOUT, adr, $time);
         $display("TEST FAILED");
         $fatal(1, "wishbone access timed out");
      end
      check_count("wb_o.ack latency", edges, ACK_LATENCY);
      rdata = wb_rsp.dat;
      @(negedge clk);
      // single-cycle ack
      check_word("wb_o.ack", word_t'(wb_rsp.ack), '0);
      wb_req = '0;
   endtask

   // access plus reference check, reads compared and writes mirrored
   task automatic do_access(input logic we, input logic [2:0] bank, input logic port,
                            input logic [9:0] idx, input wmask_t sel, input word_t dat,
                            output word_t rdata);
      logic [31:0] adr;
      word_t       exp;
      adr = make_adr(bank, port, idx);
      exp = expect_read(mode, adr);
      wb_access(we, adr, sel, dat, rdata);
      if (!we) begin
         check_word("wb_o.dat", rdata, exp);
      end else begin
         ref_write(mode, adr, sel, dat);
      end
   endtask

   // every word known before the tests, pattern mixes all index bits
   task automatic fill_all_banks();
      word_t rdata;
      word_t pat;
      for (int b = 0; b < NUM_BANKS; b++) begin
         for (int i = 0; i < (1 << BANK_ADDR_W[b]); i++) begin
            pat = word_t'((i * 32'h9e37_79b9) ^ (i >> 8) ^ (b << 24));
            do_access(1'b1, 3'(b), 1'b0, 10'(i), 4'hf, pat, rdata);
         end
      end
   endtask

   task automatic full_word_rw();
      word_t rdata;
      word_t wdata;
      logic [9:0] idx;
      for (int b = 1; b < NUM_BANKS; b++) begin
         for (int n = 0; n < 8; n++) begin
            idx   = 10'($urandom_range(0, (1 << BANK_ADDR_W[b]) - 1));
            wdata = $urandom;
            do_access(1'b1, 3'(b), 1'b0, idx, 4'hf, wdata, rdata);
            do_access(1'b0, 3'(b), 1'b0, idx, 4'h0, '0, rdata);
            check_word("wb_o.dat", rdata, wdata);
         end
      end
   endtask

   task automatic byte_mask_writes();
      word_t rdata;
      do_access(1'b1, 3'd2, 1'b0, 10'd33, 4'hf, 32'h1122_3344, rdata);
      do_access(1'b1, 3'd2, 1'b0, 10'd33, 4'b0101, 32'haabb_ccdd, rdata);
      do_access(1'b0, 3'd2, 1'b0, 10'd33, 4'h0, '0, rdata);
      check_word("wb_o.dat", rdata, 32'h11bb_33dd);
      // sweep all masks on one word
      for (int m = 0; m < 16; m++) begin
         do_access(1'b1, 3'd2, 1'b0, 10'd200, 4'(m), $urandom, rdata);
         do_access(1'b0, 3'd2, 1'b0, 10'd200, 4'h0, '0, rdata);
      end
   endtask

   task automatic bank0_byte_lane();
      word_t rdata;
      do_access(1'b1, 3'd0, 1'b0, 10'd17, 4'hf, 32'ha5c3_1e77, rdata);
      do_access(1'b0, 3'd0, 1'b0, 10'd17, 4'h0, '0, rdata);
      check_word("wb_o.dat", rdata, 32'h0000_0077);
      // read-only port sees the same word
      do_access(1'b0, 3'd0, 1'b1, 10'd17, 4'h0, '0, rdata);
      check_word("wb_o.dat", rdata, 32'h0000_0077);
      // port 1 write and a mask without bit 0 leave it alone
      do_access(1'b1, 3'd0, 1'b1, 10'd17, 4'hf, 32'h0000_0011, rdata);
      do_access(1'b1, 3'd0, 1'b0, 10'd17, 4'b1110, 32'h2222_2222, rdata);
      do_access(1'b0, 3'd0, 1'b0, 10'd17, 4'h0, '0, rdata);
      check_word("wb_o.dat", rdata, 32'h0000_0077);
   endtask

   task automatic wrap_and_unmapped();
      word_t rdata;
      // 300 mod 256 and 600 mod 512
      do_access(1'b1, 3'd1, 1'b0, 10'd300, 4'hf, 32'hc0de_0001, rdata);
      do_access(1'b0, 3'd1, 1'b0, 10'd44, 4'h0, '0, rdata);
      check_word("wb_o.dat", rdata, 32'hc0de_0001);
      do_access(1'b1, 3'd2, 1'b0, 10'd600, 4'hf, 32'hc0de_0002, rdata);
      do_access(1'b0, 3'd2, 1'b1, 10'd88, 4'h0, '0, rdata);
      check_word("wb_o.dat", rdata, 32'hc0de_0002);
      for (int b = 3; b < 8; b++) begin
         do_access(1'b1, 3'(b), 1'b0, 10'd44, 4'hf, 32'hdead_beef, rdata);
         do_access(1'b0, 3'(b), 1'b0, 10'd44, 4'h0, '0, rdata);
         do_access(1'b0, 3'(b), 1'b1, 10'd44, 4'h0, '0, rdata);
      end
      do_access(1'b0, 3'd1, 1'b0, 10'd44, 4'h0, '0, rdata);
   endtask

   task automatic inactive_modes();
      mode_t off_modes [3] = '{MODE_LA, MODE_GPIO, MODE_RRAM};
      word_t rdata;
      for (int k = 0; k < 3; k++) begin
         mode = off_modes[k];
         for (int b = 0; b < NUM_BANKS; b++) begin
            do_access(1'b1, 3'(b), 1'b0, 10'd5, 4'hf, $urandom, rdata);
            do_access(1'b0, 3'(b), 1'b0, 10'd5, 4'h0, '0, rdata);
            do_access(1'b0, 3'(b), 1'b1, 10'd5, 4'h0, '0, rdata);
         end
      end
      // memory untouched, seen back in wishbone mode
      mode = MODE_WB;
      for (int b = 0; b < NUM_BANKS; b++) begin
         do_access(1'b0, 3'(b), 1'b0, 10'd5, 4'h0, '0, rdata);
      end
   endtask

   task automatic random_accesses();
      word_t rdata;
      for (int n = 0; n < 200; n++) begin
         do_access(1'($urandom), 3'($urandom_range(0, 4)), 1'($urandom),
                   10'($urandom), 4'($urandom), $urandom, rdata);
      end
   endtask

   initial begin
      #(WATCHDOG_T);
      $display("watchdog expired before the tests finished at time %0t", $time);
      $display("TEST FAILED");
      $fatal(1, "simulation hung");
   end

   initial begin
      void'($urandom(32'hebdc_81da));
      clk    = 1'b0;
      rstn   = 1'b0;
      mode   = MODE_WB;
      wb_req = '0;
      for (int b = 0; b < NUM_BANKS; b++) begin
         for (int i = 0; i < (1 << MAX_ADDR_W); i++) begin
            ref_mem[b][i] = '0;
         end
      end
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rstn = 1'b1;
      // no ack coming out of reset
      check_word("wb_o.ack", word_t'(wb_rsp.ack), '0);
      fill_all_banks();
      full_word_rw();
      byte_mask_writes();
      bank0_byte_lane();
      wrap_and_unmapped();
      inactive_modes();
      random_accesses();
      $display("TEST PASSED");
      $finish;
   end

endmodule

//--- sim.f
logic/sram_tc_pkg.sv
logic/wb_pkg.sv
logic/sram_1rw1r.sv
logic/dout_capture.sv
logic/wb_sram_ctrl.sv
logic/sram_testchip_top.sv
dv/tb_sram_testchip.sv

//--- Makefile
TOP := tb_sram_testchip

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sim.f -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	grep -q "^TEST PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
